/* logic/boot_macros.svh */
`ifndef BOOT_MACROS_SVH
`define BOOT_MACROS_SVH

////////////////////////////////////////
// Word and lane geometry
////////////////////////////////////////

// Instruction word and its byte enables
`define BOOT_WORD_W      32
`define BOOT_BE_W        4

////////////////////////////////////////
// Instruction memory
////////////////////////////////////////

`define BOOT_QMEM_DEPTH  1024
`define BOOT_QADDR_W     10

////////////////////////////////////////
// Configuration register map
////////////////////////////////////////

`define BOOT_CFG_AW      2

// Word-addressed register offsets
`define BOOT_CFG_BASE    2'd0
`define BOOT_CFG_COUNT   2'd1
`define BOOT_CFG_CTRL    2'd2

`endif

/* logic/boot_pkg.sv */
`include "boot_macros.svh"

package boot_pkg;

   ////////////////////////////////////////
   // Data path vectors
   ////////////////////////////////////////

   // One instruction word and its byte enables
   typedef logic [`BOOT_WORD_W-1:0]  word_t;
   typedef logic [`BOOT_BE_W-1:0]    be_t;

   // Word address into the instruction memory
   typedef logic [`BOOT_QADDR_W-1:0] qaddr_t;

   // One bit wider than the address so a full memory fits
   typedef logic [`BOOT_QADDR_W:0]   wcount_t;

   typedef logic [`BOOT_CFG_AW-1:0]  cfg_addr_t;

   ////////////////////////////////////////
   // Loader FSM
   ////////////////////////////////////////

   typedef enum logic [1:0] {IDLE, LOAD, DRAIN, DONE} load_state_e;

endpackage

/* logic/boot_cfg_regs.sv */
`timescale 1ns/1ps
`include "boot_macros.svh"

module boot_cfg_regs
   import boot_pkg::*;
(
   input  logic      clk_load,
   input  logic      rst_i,
   input  logic      cfg_we_i,
   input  cfg_addr_t cfg_addr_i,
   input  word_t     cfg_wdata_i,
   input  logic      busy_i,
   output word_t     cfg_rdata_o,
   output qaddr_t    base_addr_o,
   output wcount_t   word_count_o,
   output logic      big_endian_o
);

   qaddr_t  base_q;
   wcount_t count_q;
   logic    big_endian_q;
   logic    wr_en;

   // Settings are frozen while an image is loading
   assign wr_en = cfg_we_i && !busy_i;

   always_ff @(posedge clk_load)
   begin
      if (rst_i)
      begin
         base_q       <= '0;
         count_q      <= '0;
         big_endian_q <= 1'b0;
      end
      else if (wr_en)
      begin
         case (cfg_addr_i)
            `BOOT_CFG_BASE:  base_q       <= cfg_wdata_i[`BOOT_QADDR_W-1:0];
            `BOOT_CFG_COUNT: count_q      <= cfg_wdata_i[`BOOT_QADDR_W:0];
            `BOOT_CFG_CTRL:  big_endian_q <= cfg_wdata_i[0];
            default:         ;
         endcase
      end
   end

   // Readback with unused bits as zero
   always_comb
   begin
      case (cfg_addr_i)
         `BOOT_CFG_BASE:  cfg_rdata_o = {{(`BOOT_WORD_W-`BOOT_QADDR_W){1'b0}}, base_q};
         `BOOT_CFG_COUNT: cfg_rdata_o = {{(`BOOT_WORD_W-`BOOT_QADDR_W-1){1'b0}}, count_q};
         `BOOT_CFG_CTRL:  cfg_rdata_o = {{(`BOOT_WORD_W-1){1'b0}}, big_endian_q};
         default:         cfg_rdata_o = '0;
      endcase
   end

   assign base_addr_o  = base_q;
   assign word_count_o = count_q;
   assign big_endian_o = big_endian_q;

   // A load in progress sees constant settings
   a_cfg_stable_busy: assert property (@(posedge clk_load) disable iff (rst_i)
      busy_i |=> $stable({base_q, count_q, big_endian_q}));

endmodule

/* logic/image_loader.sv */
`timescale 1ns/1ps
`include "boot_macros.svh"

module image_loader
   import boot_pkg::*;
(
   input  logic    clk_load,
   input  logic    rst_i,
   input  logic    start_i,
   input  qaddr_t  base_addr_i,
   input  wcount_t word_count_i,
   input  word_t   img_data_i,
   input  be_t     img_be_i,
   output logic    img_rd_o,
   output wcount_t img_idx_o,
   output logic    beat_valid_o,
   output qaddr_t  beat_addr_o,
   output word_t   beat_data_o,
   output be_t     beat_be_o,
   output logic    busy_o,
   output logic    load_done_o
);

   load_state_e state_q;
   wcount_t     idx_q;
   wcount_t     idx_next;
   wcount_t     rd_idx_q;
   logic        rd_q;

   assign idx_next = idx_q + wcount_t'(1);

   ////////////////////////////////////////
   // Sequencing FSM
   ////////////////////////////////////////

   always_ff @(posedge clk_load)
   begin
      if (rst_i)
      begin
         state_q <= IDLE;
         idx_q   <= '0;
         rd_q    <= 1'b0;
      end
      else
      begin
         // Source answers one cycle after each read
         rd_q <= img_rd_o;
         case (state_q)
            IDLE, DONE:
               if (start_i)
               begin
                  idx_q   <= '0;
                  // Empty image skips straight to the drain
                  state_q <= (word_count_i == '0) ? DRAIN : LOAD;
               end
            LOAD:
            begin
               idx_q <= idx_next;
               if (idx_next == word_count_i)
                  state_q <= DRAIN;
            end
            // Last beat is in the write stage once rd_q drops
            DRAIN:
               if (!rd_q)
                  state_q <= DONE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // Index of the word now on the image port
   always_ff @(posedge clk_load)
   begin
      rd_idx_q <= idx_q;
   end

   assign img_rd_o    = (state_q == LOAD);
   assign img_idx_o   = idx_q;
   assign busy_o      = (state_q == LOAD) || (state_q == DRAIN);
   assign load_done_o = (state_q == DONE);

   ////////////////////////////////////////
   // Write beats wrapping at memory depth
   ////////////////////////////////////////

   assign beat_valid_o = rd_q;
   assign beat_addr_o  = base_addr_i + rd_idx_q[`BOOT_QADDR_W-1:0];
   assign beat_data_o  = img_data_i;
   assign beat_be_o    = img_be_i;

   // Nothing left in flight once done is reported
   a_done_quiet: assert property (@(posedge clk_load) disable iff (rst_i)
      load_done_o |-> !img_rd_o && !beat_valid_o);

   a_idx_in_range: assert property (@(posedge clk_load) disable iff (rst_i)
      busy_o |-> idx_q <= word_count_i);

endmodule

/* logic/qmem_write_ctrl.sv */
`timescale 1ns/1ps
`include "boot_macros.svh"

module qmem_write_ctrl
   import boot_pkg::*;
(
   input  logic   clk_load,
   input  logic   rst_i,
   input  logic   beat_valid_i,
   input  qaddr_t beat_addr_i,
   input  word_t  beat_data_i,
   input  be_t    beat_be_i,
   input  logic   big_endian_i,
   output logic   qmem_we_o,
   output qaddr_t qmem_addr_o,
   output word_t  qmem_wdata_o,
   output be_t    qmem_be_o
);

   word_t swap_data;
   be_t   swap_be;

   // Lane swap where byte i trades with byte 3-i
   always_comb
   begin
      for (int i = 0; i < `BOOT_BE_W; i++)
      begin
         swap_data[8*i +: 8] = beat_data_i[8*(`BOOT_BE_W-1-i) +: 8];
         swap_be[i]          = beat_be_i[`BOOT_BE_W-1-i];
      end
   end

   always_ff @(posedge clk_load)
   begin
      if (rst_i)
         qmem_we_o <= 1'b0;
      else
         qmem_we_o <= beat_valid_i;
   end

   // Payload follows the beat
   always_ff @(posedge clk_load)
   begin
      qmem_addr_o  <= beat_addr_i;
      qmem_wdata_o <= big_endian_i ? swap_data : beat_data_i;
      qmem_be_o    <= big_endian_i ? swap_be : beat_be_i;
   end

   a_be_kept: assert property (@(posedge clk_load) disable iff (rst_i)
      beat_valid_i && (beat_be_i != '0) |=> qmem_we_o && (qmem_be_o != '0));

endmodule

/* logic/iqmem.sv */
`timescale 1ns/1ps
`include "boot_macros.svh"

module iqmem
   import boot_pkg::*;
(
   input  logic   clk_load,
   input  logic   we_i,
   input  qaddr_t addr_i,
   input  word_t  wdata_i,
   input  be_t    be_i,
   input  qaddr_t fetch_addr_i,
   output word_t  fetch_data_o
);

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   word_t mem [0:`BOOT_QMEM_DEPTH-1];
   word_t fetch_q;

   // Loader write port with one lane per enable
   always_ff @(posedge clk_load)
   begin
      if (we_i)
      begin
         for (int b = 0; b < `BOOT_BE_W; b++)
         begin
            if (be_i[b])
               mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

   ////////////////////////////////////////
   // Fetch port
   ////////////////////////////////////////

   // Same-address write shows up on the next fetch
   always_ff @(posedge clk_load)
   begin
      fetch_q <= mem[fetch_addr_i];
   end

   assign fetch_data_o = fetch_q;

endmodule

/* logic/boot_top.sv */
`timescale 1ns/1ps

module boot_top
   import boot_pkg::*;
(
   input  logic      clk_load,
   input  logic      rst_i,
   input  logic      cfg_we_i,
   input  cfg_addr_t cfg_addr_i,
   input  word_t     cfg_wdata_i,
   input  logic      start_i,
   input  word_t     img_data_i,
   input  be_t       img_be_i,
   input  qaddr_t    fetch_addr_i,
   output word_t     cfg_rdata_o,
   output logic      img_rd_o,
   output wcount_t   img_idx_o,
   output logic      busy_o,
   output logic      load_done_o,
   output word_t     fetch_data_o
);

   // Settings
   qaddr_t  base_addr;
   wcount_t word_count;
   logic    big_endian;

   // Loader beats
   logic    beat_valid;
   qaddr_t  beat_addr;
   word_t   beat_data;
   be_t     beat_be;

   // Memory write port
   logic    qmem_we;
   qaddr_t  qmem_addr;
   word_t   qmem_wdata;
   be_t     qmem_be;

   boot_cfg_regs u_cfg (
      .clk_load     (clk_load),
      .rst_i        (rst_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .busy_i       (busy_o),
      .cfg_rdata_o  (cfg_rdata_o),
      .base_addr_o  (base_addr),
      .word_count_o (word_count),
      .big_endian_o (big_endian)
   );

   image_loader u_loader (
      .clk_load     (clk_load),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .base_addr_i  (base_addr),
      .word_count_i (word_count),
      .img_data_i   (img_data_i),
      .img_be_i     (img_be_i),
      .img_rd_o     (img_rd_o),
      .img_idx_o    (img_idx_o),
      .beat_valid_o (beat_valid),
      .beat_addr_o  (beat_addr),
      .beat_data_o  (beat_data),
      .beat_be_o    (beat_be),
      .busy_o       (busy_o),
      .load_done_o  (load_done_o)
   );

   qmem_write_ctrl u_wctrl (
      .clk_load     (clk_load),
      .rst_i        (rst_i),
      .beat_valid_i (beat_valid),
      .beat_addr_i  (beat_addr),
      .beat_data_i  (beat_data),
      .beat_be_i    (beat_be),
      .big_endian_i (big_endian),
      .qmem_we_o    (qmem_we),
      .qmem_addr_o  (qmem_addr),
      .qmem_wdata_o (qmem_wdata),
      .qmem_be_o    (qmem_be)
   );

   iqmem u_iqmem (
      .clk_load     (clk_load),
      .we_i         (qmem_we),
      .addr_i       (qmem_addr),
      .wdata_i      (qmem_wdata),
      .be_i         (qmem_be),
      .fetch_addr_i (fetch_addr_i),
      .fetch_data_o (fetch_data_o)
   );

endmodule

/* tb/tb_boot_top.sv */
`timescale 1ns/1ps
`include "boot_macros.svh"

module tb_boot_top
   import boot_pkg::*;
();

   localparam int DEPTH       = `BOOT_QMEM_DEPTH;
   localparam int TOTAL_WORDS = 64 + 80 + 16;
   localparam int WATCHDOG_NS = 4 * TOTAL_WORDS * 20 + 10000;

   logic      clk_load;
   logic      rst_i;
   logic      cfg_we_i;
   cfg_addr_t cfg_addr_i;
   word_t     cfg_wdata_i;
   logic      start_i;
   word_t     img_data_i;
   be_t       img_be_i;
   qaddr_t    fetch_addr_i;
   word_t     cfg_rdata_o;
   logic      img_rd_o;
   wcount_t   img_idx_o;
   logic      busy_o;
   logic      load_done_o;
   word_t     fetch_data_o;

   // Image held by the source, and the expected memory with its known lanes
   word_t   img_words [0:DEPTH-1];
   be_t     img_bes   [0:DEPTH-1];
   word_t   ref_mem   [0:DEPTH-1];
   be_t     ref_known [0:DEPTH-1];

   logic    rd_seen;
   wcount_t idx_seen;
   int      rd_count;
   int      pass_count;
   int      fail_count;
   int      test_errs;
   int      base3;

   boot_top u_boot_top (
      .clk_load     (clk_load),
      .rst_i        (rst_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .start_i      (start_i),
      .img_data_i   (img_data_i),
      .img_be_i     (img_be_i),
      .fetch_addr_i (fetch_addr_i),
      .cfg_rdata_o  (cfg_rdata_o),
      .img_rd_o     (img_rd_o),
      .img_idx_o    (img_idx_o),
      .busy_o       (busy_o),
      .load_done_o  (load_done_o),
      .fetch_data_o (fetch_data_o)
   );

   initial clk_load = 1'b0;
   always #10 clk_load = ~clk_load;

   ////////////////////////////////////////
   // Image source model
   ////////////////////////////////////////

   // Read request taken mid-cycle while it is stable
   // Reads of one load must walk the indices from zero
   initial
   begin
      rd_seen  = 1'b0;
      idx_seen = '0;
      rd_count = 0;
      forever
      begin
         @(negedge clk_load);
         rd_seen  = img_rd_o;
         idx_seen = img_idx_o;
         if (start_i)
            rd_count = 0;
         if (img_rd_o)
         begin
            if (img_idx_o !== wcount_t'(rd_count))
               log_error($sformatf("read index %0d, expected %0d", img_idx_o, rd_count));
            rd_count++;
         end
      end
   end

   // Answer in the cycle after the read
   initial
   begin
      img_data_i = '0;
      img_be_i   = '0;
      forever
      begin
         @(posedge clk_load);
         #2;
         if (rd_seen)
         begin
            img_data_i = img_words[idx_seen[`BOOT_QADDR_W-1:0]];
            img_be_i   = img_bes[idx_seen[`BOOT_QADDR_W-1:0]];
         end
         else
         begin
            img_data_i = '0;
            img_be_i   = '0;
         end
      end
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Memory lane k takes image byte k, or byte 3-k when big-endian
   function automatic word_t merge_word(word_t old_word, word_t img_word, be_t img_be,
                                        logic big);
      word_t merged;
      int    src;
      merged = old_word;
      for (int k = 0; k < `BOOT_BE_W; k++)
      begin
         src = big ? (`BOOT_BE_W - 1 - k) : k;
         if (img_be[src])
            merged[8*k +: 8] = img_word[8*src +: 8];
      end
      return merged;
   endfunction

   function automatic be_t lanes_hit(be_t img_be, logic big);
      be_t lanes;
      for (int k = 0; k < `BOOT_BE_W; k++)
         lanes[k] = big ? img_be[`BOOT_BE_W-1-k] : img_be[k];
      return lanes;
   endfunction

   function automatic word_t bytes_of(be_t lanes);
      word_t mask;
      for (int k = 0; k < `BOOT_BE_W; k++)
         mask[8*k +: 8] = {8{lanes[k]}};
      return mask;
   endfunction

   task automatic merge_image(int base, int count, logic big);
      int a;
      for (int i = 0; i < count; i++)
      begin
         a = (base + i) % DEPTH;
         ref_mem[a]   = merge_word(ref_mem[a], img_words[i], img_bes[i], big);
         ref_known[a] = ref_known[a] | lanes_hit(img_bes[i], big);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus and checking tasks
   ////////////////////////////////////////

   task automatic step();
      @(posedge clk_load);
      #2;
   endtask

   task automatic log_error(string msg);
      $display("[FAIL] %0t %s", $time, msg);
      fail_count++;
      test_errs++;
   endtask

   task automatic log_problem(string msg);
      $display("%s", msg);
      fail_count++;
      test_errs++;
   endtask

   task automatic end_test(int num, string name);
      $display("Test %0d %s finished with %0d errors", num, name, test_errs);
      test_errs = 0;
   endtask

   task automatic cfg_write(cfg_addr_t addr, word_t data);
      step();
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      step();
      cfg_we_i    = 1'b0;
   endtask

   task automatic cfg_expect(cfg_addr_t addr, word_t exp);
      step();
      cfg_addr_i = addr;
      #1;
      if (cfg_rdata_o !== exp)
         log_error($sformatf("cfg reg %0d read %h, expected %h", addr, cfg_rdata_o, exp));
      else
         pass_count++;
   endtask

   task automatic configure(int base, int count, logic big);
      cfg_write(`BOOT_CFG_BASE, word_t'(base));
      cfg_write(`BOOT_CFG_COUNT, word_t'(count));
      cfg_write(`BOOT_CFG_CTRL, {31'b0, big});
   endtask

   task automatic fill_image(int count, logic all_be);
      for (int i = 0; i < count; i++)
      begin
         img_words[i] = $urandom;
         img_bes[i]   = all_be ? 4'hF : be_t'($urandom);
      end
   endtask

   task automatic start_load();
      step();
      start_i = 1'b1;
      step();
      start_i = 1'b0;
   endtask

   // Cycles counted from the one in which start was driven
   task automatic wait_done(int exp_cycles, int limit);
      int cycles;
      cycles = 1;
      while (!load_done_o && cycles < limit)
      begin
         if (busy_o !== 1'b1)
            log_error("busy_o low while the load runs");
         step();
         cycles++;
      end
      if (!load_done_o)
         log_problem($sformatf("load_done_o never rose within %0d cycles", limit));
      else if (exp_cycles > 0 && cycles != exp_cycles)
         log_error($sformatf("load_done_o after %0d cycles, expected %0d",
                             cycles, exp_cycles));
      else if (busy_o !== 1'b0)
         log_error("busy_o still high with load_done_o");
      else
         pass_count++;
   endtask

   task automatic check_read_count(int count);
      if (rd_count != count)
         log_error($sformatf("%0d image reads, expected %0d", rd_count, count));
      else
         pass_count++;
   endtask

   // One fetch per cycle with data a cycle later
   task automatic check_memory(string tag);
      qaddr_t addrs[$];
      qaddr_t a;
      word_t  mask;
      for (int i = 0; i < DEPTH; i++)
         if (ref_known[i] != '0)
            addrs.push_back(qaddr_t'(i));
      for (int i = 0; i <= addrs.size(); i++)
      begin
         step();
         if (i > 0)
         begin
            a    = addrs[i-1];
            mask = bytes_of(ref_known[a]);
            if ((fetch_data_o & mask) !== (ref_mem[a] & mask))
               log_error($sformatf("%s addr %0d fetched %h, expected %h lanes %b",
                                   tag, a, fetch_data_o, ref_mem[a], ref_known[a]));
            else
               pass_count++;
         end
         if (i < addrs.size())
            fetch_addr_i = addrs[i];
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      void'($urandom(32'h4336_4528));
      $timeformat(-9, 1, " ns", 0);
      rst_i        = 1'b1;
      cfg_we_i     = 1'b0;
      cfg_addr_i   = '0;
      cfg_wdata_i  = '0;
      start_i      = 1'b0;
      fetch_addr_i = '0;
      pass_count   = 0;
      fail_count   = 0;
      test_errs    = 0;
      for (int i = 0; i < DEPTH; i++)
      begin
         ref_mem[i]   = '0;
         ref_known[i] = '0;
      end
      repeat (4) @(posedge clk_load);
      #2;
      rst_i = 1'b0;

      if (busy_o !== 1'b0 || load_done_o !== 1'b0 || img_rd_o !== 1'b0)
         log_error($sformatf("after reset busy %b done %b rd %b",
                             busy_o, load_done_o, img_rd_o));
      else
         pass_count++;
      for (int r = 0; r < 4; r++)
         cfg_expect(cfg_addr_t'(r), '0);
      end_test(1, "reset state");

      // Upper bits of each write are dropped on readback
      cfg_write(`BOOT_CFG_BASE, 32'hABCD_E5A5);
      cfg_write(`BOOT_CFG_COUNT, 32'h1234_5F0F);
      cfg_write(`BOOT_CFG_CTRL, 32'hFFFF_FFFF);
      cfg_expect(`BOOT_CFG_BASE, 32'hABCD_E5A5 & 32'h3FF);
      cfg_expect(`BOOT_CFG_COUNT, 32'h1234_5F0F & 32'h7FF);
      cfg_expect(`BOOT_CFG_CTRL, 32'h1);
      cfg_write(`BOOT_CFG_CTRL, 32'hFFFF_FFFE);
      cfg_expect(`BOOT_CFG_CTRL, 32'h0);
      end_test(2, "config readback");

      base3 = 940 + int'($urandom % 40);
      fill_image(64, 1'b1);
      configure(base3, 64, 1'b0);
      start_load();
      wait_done(64 + 3, 64 + 40);
      check_read_count(64);
      merge_image(base3, 64, 1'b0);
      check_memory("little-endian");
      end_test(3, "little-endian load");

      // Overlaps the first image and runs past the top of memory
      fill_image(80, 1'b0);
      configure((base3 + 32) % DEPTH, 80, 1'b1);
      start_load();
      wait_done(80 + 3, 80 + 40);
      check_read_count(80);
      merge_image((base3 + 32) % DEPTH, 80, 1'b1);
      check_memory("big-endian");
      end_test(4, "big-endian overlay");

      fill_image(16, 1'b0);
      configure(base3 + 8, 16, 1'b0);
      start_load();
      cfg_write(`BOOT_CFG_BASE, 32'h3);
      cfg_write(`BOOT_CFG_COUNT, 32'h5);
      cfg_write(`BOOT_CFG_CTRL, 32'h1);
      wait_done(0, 60);
      check_read_count(16);
      cfg_expect(`BOOT_CFG_BASE, word_t'(base3 + 8));
      cfg_expect(`BOOT_CFG_COUNT, 32'd16);
      cfg_expect(`BOOT_CFG_CTRL, 32'h0);
      merge_image(base3 + 8, 16, 1'b0);
      check_memory("busy writes");
      // Fresh image so that any stray write would differ from memory
      fill_image(16, 1'b1);
      cfg_write(`BOOT_CFG_COUNT, 32'h0);
      start_load();
      wait_done(2, 20);
      check_read_count(0);
      check_memory("empty load");
      end_test(5, "locked config and empty load");

      $display("Checks passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // Four cycles per image word plus margin for setup and readback
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* sources.f */
+incdir+logic
logic/boot_pkg.sv
logic/boot_cfg_regs.sv
logic/image_loader.sv
logic/qmem_write_ctrl.sv
logic/iqmem.sv
logic/boot_top.sv
tb/tb_boot_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the boot loader testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_boot_top \
   -f sources.f -o tb_boot_top > sim.log 2>&1 \
   && ./obj_dir/tb_boot_top >> sim.log 2>&1 \
   || echo "RESULT: FAIL" >> sim.log

cat sim.log

grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
